// File: fas_top.f
source/fas_pkg.sv
source/fir_filter.sv
source/frame_collector.sv
source/fft_stage.sv
source/fft16.sv
source/peak_bin_detector.sv
source/fas_top.sv
sim/fas_assert.sv
sim/fas_tb.sv

// File: Bender.yml
package:
  name: fas

sources:
  - source/fas_pkg.sv
  - source/fir_filter.sv
  - source/frame_collector.sv
  - source/fft_stage.sv
  - source/fft16.sv
  - source/peak_bin_detector.sv
  - source/fas_top.sv
  - target: simulation
    files:
      - sim/fas_assert.sv
      - sim/fas_tb.sv

// File: sim/fas_tb.sv
`timescale 1ns/10ps

module fas_tb;

  localparam int NUM_TAPS       = fas_pkg::NUM_TAPS;
  localparam int FRAME_LEN      = fas_pkg::FFT_N;
  localparam int NUM_FRAMES     = 3;
  localparam int STREAM_SAMPLES = NUM_TAPS - 1 + NUM_FRAMES * FRAME_LEN;
  localparam int TOTAL_SAMPLES  = NUM_TAPS + 2 * NUM_TAPS + 5 * STREAM_SAMPLES;
  localparam int TIMEOUT_NS     = TOTAL_SAMPLES * 200 + 20000;
  localparam int DONE_LATENCY   = 6;

  localparam int KIND_DC      = 0;
  localparam int KIND_SQUARE8 = 1;
  localparam int KIND_SINE16  = 2;

  logic                      clk;
  logic                      rst;
  logic                      data_valid_i;
  fas_pkg::sample_t          data_i;
  logic                      fir_valid_o;
  fas_pkg::sample_t          fir_d_o;
  logic                      done_o;
  logic [fas_pkg::BIN_W-1:0] freq_o;

  // bookkeeping cleared on every reset
  int cyc;
  int fir_cnt;
  int done_cnt;
  int last_fir_cyc;
  int exp_freq;  // negative means do not check
  int frame_q [$];
  fas_pkg::sample_t fir_q [$];

  fas_top fas_top_inst (
    .clk         (clk),
    .rst         (rst),
    .data_valid_i(data_valid_i),
    .data_i      (data_i),
    .fir_valid_o (fir_valid_o),
    .fir_d_o     (fir_d_o),
    .done_o      (done_o),
    .freq_o      (freq_o)
  );

  bind fas_top fas_assert fas_assert_inst (
    .clk         (clk),
    .rst         (rst),
    .data_valid_i(data_valid_i),
    .fir_valid_i (fir_valid_o),
    .done_i      (done_o),
    .freq_i      (freq_o)
  );

  always #50 clk = ~clk;

  task automatic stop_with_failure();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped after first error");
  endtask

  task automatic check(input logic signed [63:0] actual, input logic signed [63:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("[ERROR] t=%0t: %s: got %0d, expected %0d", $time, msg, actual, expected);
      stop_with_failure();
    end
  endtask

  // outputs seen here were set by the previous rising edge
  task automatic observe();
    int frame_end;
    if (fir_valid_o) begin
      fir_cnt++;
      last_fir_cyc = cyc;
      fir_q.push_back(fir_d_o);
      if (fir_cnt % FRAME_LEN == 0) begin
        frame_q.push_back(cyc);  // 16th sample of a frame
      end
    end
    if (done_o) begin
      done_cnt++;
      if (frame_q.size() == 0) begin
        $display("done_o pulsed at %0t with no completed frame before it", $time);
        stop_with_failure();
      end else begin
        frame_end = frame_q.pop_front();
        check(cyc - frame_end, DONE_LATENCY, "done_o latency after last fir_valid_o");
        if (exp_freq >= 0) begin
          check(freq_o, exp_freq, "peak bin on done_o");
        end
      end
    end
  endtask

  task automatic tick(input logic valid, input fas_pkg::sample_t sample);
    @(negedge clk);
    cyc++;
    observe();
    data_valid_i = valid;
    data_i       = sample;
  endtask

  task automatic idle(input int n);
    repeat (n) tick(1'b0, '0);
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst          = 1'b1;
    data_valid_i = 1'b0;
    data_i       = '0;
    repeat (5) @(negedge clk);
    rst          = 1'b0;
    cyc          = 0;
    fir_cnt      = 0;
    done_cnt     = 0;
    last_fir_cyc = -1;
    exp_freq     = -1;
    frame_q.delete();
    fir_q.delete();
  endtask

  function automatic fas_pkg::sample_t tone_sample(input int kind, input int n);
    int sine16 [16];
    sine16 = '{0, 3061, 5657, 7391, 8000, 7391, 5657, 3061,
               0, -3061, -5657, -7391, -8000, -7391, -5657, -3061};
    case (kind)
      KIND_SQUARE8: return ((n % 8) < 4) ? 16'sd8000 : -16'sd8000;
      KIND_SINE16:  return fas_pkg::sample_t'(sine16[n % 16]);
      default:      return 16'sd8000;
    endcase
  endfunction

  task automatic reset_state_test();
    apply_reset();
    check(fir_valid_o, 0, "fir_valid_o after reset");
    check(done_o, 0, "done_o after reset");
    check(freq_o, 0, "freq_o after reset");
  endtask

  task automatic fill_test();
    int fill_cyc;
    apply_reset();
    repeat (NUM_TAPS - 1) tick(1'b1, 16'sd100);
    idle(1);
    check(fir_cnt, 0, "fir_valid_o during window fill");
    tick(1'b1, 16'sd100);
    fill_cyc = cyc;
    idle(1);
    check(fir_cnt, 1, "fir_valid_o count after last fill sample");
    check(last_fir_cyc, fill_cyc + 1, "cycle of first fir_valid_o");
  endtask

  task automatic impulse_test();
    longint coef;
    longint prod;
    longint expected;
    apply_reset();
    repeat (NUM_TAPS) tick(1'b1, '0);
    tick(1'b1, 16'sd16384);
    repeat (NUM_TAPS - 1) tick(1'b1, '0);
    idle(2);
    check(fir_q.size(), NUM_TAPS + 1, "impulse response length");
    check(fir_q[0], 0, "output of zero window");
    for (int k = 0; k < NUM_TAPS; k++) begin
      coef     = fas_pkg::fir_coef[k];
      prod     = coef * 64'sd16384;
      expected = (prod >>> 16) + ((prod < 0) ? 1 : 0);  // negative sums round up by one
      check(fir_q[k+1], expected, $sformatf("impulse response tap %0d", k));
    end
  endtask

  // stream a tone after reset with optional random idle cycles
  task automatic stream_test(input int kind, input int freq, input bit gaps);
    apply_reset();
    exp_freq = freq;
    for (int n = 0; n < STREAM_SAMPLES; n++) begin
      if (gaps) begin
        idle($urandom % 2);
      end
      tick(1'b1, tone_sample(kind, n));
    end
    idle(DONE_LATENCY + 4);
    check(fir_cnt, NUM_FRAMES * FRAME_LEN, "filtered sample count");
    check(done_cnt, NUM_FRAMES, "done_o pulse count");
    check(freq_o, freq, "final peak bin");
  endtask

  // a failing bound assertion ends the run at once
  always @(fas_top_inst.fas_assert_inst.fail_cnt) begin
    if (fas_top_inst.fas_assert_inst.fail_cnt != 0) begin
      $display("bound assertion failed at %0t", $time);
      stop_with_failure();
    end
  end

  initial begin
    timeout_watch: begin
      #(TIMEOUT_NS);
      $display("run timed out after %0d ns without finishing the tests", TIMEOUT_NS);
      stop_with_failure();
    end
  end

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    data_valid_i = 1'b0;
    data_i       = '0;
    void'($urandom(32'h4525));

    reset_state_test();
    fill_test();
    impulse_test();
    stream_test(KIND_DC, 0, 1'b0);
    stream_test(KIND_SQUARE8, 2, 1'b0);
    stream_test(KIND_SINE16, 1, 1'b0);
    stream_test(KIND_SQUARE8, 2, 1'b1);
    stream_test(KIND_SINE16, 1, 1'b1);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: sim/fas_assert.sv
`timescale 1ns/10ps

module fas_assert (
  input logic                      clk,
  input logic                      rst,
  input logic                      data_valid_i,
  input logic                      fir_valid_i,
  input logic                      done_i,
  input logic [fas_pkg::BIN_W-1:0] freq_i
);

  int fail_cnt = 0;  // watched by the testbench

  done_single: assert property (@(posedge clk) disable iff (rst) done_i |=> !done_i)
    else begin
      fail_cnt++;
      $error("done_o high on two consecutive cycles");
    end

  // each filtered sample needs an accepted input one cycle earlier
  fir_after_sample: assert property (@(posedge clk) disable iff (rst)
    fir_valid_i |-> $past(data_valid_i))
    else begin
      fail_cnt++;
      $error("fir_valid_o without an accepted sample on the cycle before");
    end

  freq_range: assert property (@(posedge clk) disable iff (rst) freq_i <= 4'd8)
    else begin
      fail_cnt++;
      $error("freq_o above bin 8");
    end

endmodule

// File: source/fas_top.sv
`timescale 1ns/10ps

module fas_top #(
  parameter int NUM_TAPS   = fas_pkg::NUM_TAPS,
  parameter int FFT_N      = fas_pkg::FFT_N,
  parameter int FFT_STAGES = fas_pkg::FFT_STAGES
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      data_valid_i,
  input  fas_pkg::sample_t          data_i,
  output logic                      fir_valid_o,
  output fas_pkg::sample_t          fir_d_o,
  output logic                      done_o,
  output logic [fas_pkg::BIN_W-1:0] freq_o
);

  logic            frame_valid;
  fas_pkg::frame_t frame;
  logic            spec_valid;
  fas_pkg::frame_t spec;

  fir_filter #(
    .NUM_TAPS(NUM_TAPS)
  ) fir_inst (
    .clk     (clk),
    .rst     (rst),
    .valid_i (data_valid_i),
    .sample_i(data_i),
    .valid_o (fir_valid_o),
    .sample_o(fir_d_o)
  );

  frame_collector #(
    .FFT_N(FFT_N)
  ) collector_inst (
    .clk          (clk),
    .rst          (rst),
    .valid_i      (fir_valid_o),
    .sample_i     (fir_d_o),
    .frame_valid_o(frame_valid),
    .frame_o      (frame)
  );

  fft16 #(
    .FFT_STAGES(FFT_STAGES)
  ) fft_inst (
    .clk          (clk),
    .rst          (rst),
    .frame_valid_i(frame_valid),
    .frame_i      (frame),
    .spec_valid_o (spec_valid),
    .spec_o       (spec)
  );

  peak_bin_detector peak_inst (
    .clk         (clk),
    .rst         (rst),
    .spec_valid_i(spec_valid),
    .spec_i      (spec),
    .done_o      (done_o),
    .freq_o      (freq_o)
  );

endmodule

// File: source/peak_bin_detector.sv
`timescale 1ns/10ps

module peak_bin_detector (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      spec_valid_i,
  input  fas_pkg::frame_t           spec_i,
  output logic                      done_o,
  output logic [fas_pkg::BIN_W-1:0] freq_o
);

  localparam int NUM_BINS = fas_pkg::FFT_N / 2 + 1;  // upper bins mirror these
  localparam int MAG_W    = 2 * fas_pkg::SAMPLE_W + 1;
  localparam int HI_LSB   = fas_pkg::PART_W - fas_pkg::SAMPLE_W;

  logic [fas_pkg::BIN_W-1:0] best_idx;

  function automatic logic [fas_pkg::BIN_W-1:0] bit_rev(input logic [fas_pkg::BIN_W-1:0] idx);
    for (int b = 0; b < fas_pkg::BIN_W; b++) begin
      bit_rev[b] = idx[fas_pkg::BIN_W-1-b];
    end
  endfunction

  always_comb begin
    logic signed [fas_pkg::SAMPLE_W-1:0] re_h;
    logic signed [fas_pkg::SAMPLE_W-1:0] im_h;
    logic [MAG_W-1:0] mag;
    logic [MAG_W-1:0] best_mag;
    best_mag = '0;
    best_idx = '0;
    for (int k = 0; k < NUM_BINS; k++) begin
      re_h = spec_i[bit_rev(fas_pkg::BIN_W'(k))].re[fas_pkg::PART_W-1:HI_LSB];
      im_h = spec_i[bit_rev(fas_pkg::BIN_W'(k))].im[fas_pkg::PART_W-1:HI_LSB];
      mag  = re_h * re_h + im_h * im_h;
      if ((k == 0) || (mag > best_mag)) begin  // strict compare keeps lower index on tie
        best_mag = mag;
        best_idx = fas_pkg::BIN_W'(k);
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      done_o <= 1'b0;
      freq_o <= '0;
    end else begin
      done_o <= spec_valid_i;
      if (spec_valid_i) begin
        freq_o <= best_idx;
      end
    end
  end

endmodule

// File: source/fft16.sv
`timescale 1ns/10ps

module fft16 #(
  parameter int FFT_STAGES = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            frame_valid_i,
  input  fas_pkg::frame_t frame_i,
  output logic            spec_valid_o,
  output fas_pkg::frame_t spec_o
);

  // element s feeds stage s
  fas_pkg::frame_t stage_data [FFT_STAGES+1];
  logic [FFT_STAGES:0] stage_valid;

  assign stage_data[0]  = frame_i;
  assign stage_valid[0] = frame_valid_i;

  for (genvar s = 0; s < FFT_STAGES; s++) begin : g_stage
    fft_stage #(
      .STAGE(s)
    ) stage_inst (
      .clk    (clk),
      .rst    (rst),
      .valid_i(stage_valid[s]),
      .data_i (stage_data[s]),
      .valid_o(stage_valid[s+1]),
      .data_o (stage_data[s+1])
    );
  end

  // bins leave in bit-reversed order
  assign spec_valid_o = stage_valid[FFT_STAGES];
  assign spec_o       = stage_data[FFT_STAGES];

endmodule

// File: source/fft_stage.sv
`timescale 1ns/10ps

module fft_stage #(
  parameter int STAGE = 0
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            valid_i,
  input  fas_pkg::frame_t data_i,
  output logic            valid_o,
  output fas_pkg::frame_t data_o
);

  localparam int N      = fas_pkg::FFT_N;
  localparam int SPAN   = N >> (STAGE + 1);  // distance between pair members
  localparam int STRIDE = 1 << STAGE;        // twiddle index step
  localparam int PROD_W = fas_pkg::PART_W + fas_pkg::TWID_W;
  localparam int FRAC_W = 16;

  fas_pkg::frame_t data_d;

  // drop Q16 fraction, negative results get one added
  function automatic logic signed [fas_pkg::PART_W-1:0] q16_round(
    input logic signed [PROD_W-1:0] prod
  );
    logic signed [PROD_W-1:0] sh;
    sh = prod >>> FRAC_W;
    return sh[fas_pkg::PART_W-1:0] + prod[PROD_W-1];
  endfunction

  always_comb begin
    int top;
    int bot;
    logic signed [fas_pkg::PART_W-1:0] dr;
    logic signed [fas_pkg::PART_W-1:0] di;
    logic signed [fas_pkg::TWID_W-1:0] wr;
    logic signed [fas_pkg::TWID_W-1:0] wi;
    logic signed [PROD_W-1:0] p_re;
    logic signed [PROD_W-1:0] p_im;
    data_d = data_i;
    for (int k = 0; k < N / 2; k++) begin
      top = (k / SPAN) * 2 * SPAN + (k % SPAN);
      bot = top + SPAN;
      wr  = fas_pkg::twiddle_re[(k % SPAN) * STRIDE];
      wi  = fas_pkg::twiddle_im[(k % SPAN) * STRIDE];

      data_d[top].re = data_i[top].re + data_i[bot].re;
      data_d[top].im = data_i[top].im + data_i[bot].im;

      dr   = data_i[top].re - data_i[bot].re;
      di   = data_i[top].im - data_i[bot].im;
      p_re = dr * wr - di * wi;  // complex multiply by twiddle
      p_im = dr * wi + di * wr;
      data_d[bot].re = q16_round(p_re);
      data_d[bot].im = q16_round(p_im);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    data_o <= data_d;
  end

endmodule

// File: source/frame_collector.sv
`timescale 1ns/10ps

module frame_collector #(
  parameter int FFT_N = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             valid_i,
  input  fas_pkg::sample_t sample_i,
  output logic             frame_valid_o,
  output fas_pkg::frame_t  frame_o
);

  localparam int SLOT_W = $clog2(FFT_N);
  localparam int SCALE  = 8;

  logic [SLOT_W-1:0] slot_q;
  logic last_slot;
  logic signed [fas_pkg::PART_W-1:0] re_ext;
  fas_pkg::cplx_t slot_d;

  assign re_ext    = sample_i;  // sign extend
  assign slot_d.re = re_ext <<< SCALE;
  assign slot_d.im = '0;

  assign last_slot = (slot_q == SLOT_W'(FFT_N - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      slot_q        <= '0;
      frame_valid_o <= 1'b0;
    end else begin
      frame_valid_o <= valid_i && last_slot;
      if (valid_i) begin
        slot_q <= last_slot ? '0 : slot_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      frame_o[slot_q] <= slot_d;
    end
  end

endmodule

// File: source/fir_filter.sv
`timescale 1ns/10ps

module fir_filter #(
  parameter int NUM_TAPS = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             valid_i,
  input  fas_pkg::sample_t sample_i,
  output logic             valid_o,
  output fas_pkg::sample_t sample_o
);

  localparam int CNT_W  = $clog2(NUM_TAPS);
  localparam int FRAC_W = 16;

  fas_pkg::fir_state_e state_q;
  logic [CNT_W-1:0] fill_cnt_q;

  fas_pkg::sample_t win_q [NUM_TAPS];
  fas_pkg::sample_t win_d [NUM_TAPS];

  logic signed [fas_pkg::ACC_W-1:0] acc;
  logic signed [fas_pkg::ACC_W-1:0] acc_sh;
  fas_pkg::sample_t fir_d;
  logic last_fill;
  logic fire;

  // window after this sample is taken, newest at tap 0
  always_comb begin
    win_d[0] = sample_i;
    for (int k = 1; k < NUM_TAPS; k++) begin
      win_d[k] = win_q[k-1];
    end
  end

  always_comb begin
    acc = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      acc = acc + fas_pkg::fir_coef[k] * win_d[k];
    end
  end

  assign acc_sh = acc >>> FRAC_W;
  assign fir_d  = acc_sh[fas_pkg::SAMPLE_W-1:0] + acc[fas_pkg::ACC_W-1];  // round up if negative

  assign last_fill = (fill_cnt_q == CNT_W'(NUM_TAPS - 1));
  assign fire      = valid_i && ((state_q == fas_pkg::RUN) || last_fill);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q    <= fas_pkg::FILL;
      fill_cnt_q <= '0;
      valid_o    <= 1'b0;
    end else begin
      valid_o <= fire;
      if (valid_i && (state_q == fas_pkg::FILL)) begin
        if (last_fill) begin
          state_q <= fas_pkg::RUN;  // window full
        end else begin
          fill_cnt_q <= fill_cnt_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      win_q <= win_d;
    end
    if (fire) begin
      sample_o <= fir_d;
    end
  end

endmodule

// File: source/fas_pkg.sv
package fas_pkg;

  localparam int SAMPLE_W   = 16;
  localparam int COEF_W     = 20;  // Q16
  localparam int ACC_W      = 42;
  localparam int NUM_TAPS   = 32;
  localparam int FFT_N      = 16;
  localparam int FFT_STAGES = 4;
  localparam int PART_W     = 32;
  localparam int TWID_W     = 32;  // Q16, one is 65536
  localparam int BIN_W      = 4;

  typedef logic signed [SAMPLE_W-1:0] sample_t;

  typedef struct packed {
    logic signed [PART_W-1:0] re;
    logic signed [PART_W-1:0] im;
  } cplx_t;

  typedef cplx_t [FFT_N-1:0] frame_t;

  typedef enum logic {
    FILL,
    RUN
  } fir_state_e;

  // hamming windowed sinc, cutoff fs/4, symmetric
  localparam logic signed [COEF_W-1:0] fir_coef [NUM_TAPS] = '{
    -20'sd76,    -20'sd91,    20'sd128,    20'sd191,
    -20'sd286,   -20'sd417,   20'sd590,    20'sd817,
    -20'sd1108,  -20'sd1487,  20'sd1992,   20'sd2693,
    -20'sd3747,  -20'sd5559,  20'sd9626,   20'sd29435,
    20'sd29435,  20'sd9626,   -20'sd5559,  -20'sd3747,
    20'sd2693,   20'sd1992,   -20'sd1487,  -20'sd1108,
    20'sd817,    20'sd590,    -20'sd417,   -20'sd286,
    20'sd191,    20'sd128,    -20'sd91,    -20'sd76
  };

  // cos(2*pi*k/16)
  localparam logic signed [TWID_W-1:0] twiddle_re [FFT_N/2] = '{
    32'sd65536,
    32'sd60547,
    32'sd46341,
    32'sd25080,
    32'sd0,
    -32'sd25080,
    -32'sd46341,
    -32'sd60547
  };

  // -sin(2*pi*k/16)
  localparam logic signed [TWID_W-1:0] twiddle_im [FFT_N/2] = '{
    32'sd0,
    -32'sd25080,
    -32'sd46341,
    -32'sd60547,
    -32'sd65536,
    -32'sd60547,
    -32'sd46341,
    -32'sd25080
  };

endpackage
